// File: hw/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

//////////////////////////////
// core sizes

`define DR_XLEN          32
`define DR_PHYS_REG_SIZE 256
`define DR_ROB_SIZE      256
`define DR_UOP_SIZE      16

//////////////////////////////
// derived field widths

`define DR_PREG_W $clog2(`DR_PHYS_REG_SIZE)
`define DR_ROB_W  $clog2(`DR_ROB_SIZE)
`define DR_UOPC_W $clog2(`DR_UOP_SIZE)

// wide enough for the five unit ids plus the empty code
`define DR_FU_W   3

`endif

// File: hw/fu_id_pkg.sv
`include "dispatch_consts.svh"

package fu_id_pkg;

    typedef enum logic [`DR_FU_W-1:0] {
        FU_NONE    = 3'd0, // never legal on the issue port
        FU_LOGICAL = 3'd1,
        FU_ARITH   = 3'd2,
        FU_BRANCH  = 3'd3,
        FU_MUL_DIV = 3'd4,
        FU_LD_ST   = 3'd5
    } fu_id_e;

    localparam int RING_LEN = 5;

    // stage order from the entry outwards
    localparam fu_id_e RING_ORDER [RING_LEN] = '{
        FU_ARITH,
        FU_LOGICAL,
        FU_BRANCH,
        FU_MUL_DIV,
        FU_LD_ST
    };

    localparam fu_id_e FU_LAST = RING_ORDER[RING_LEN-1]; // the ring is open after this one

endpackage

// File: hw/dispatch_types_pkg.sv
`include "dispatch_consts.svh"

package dispatch_types_pkg;

    //////////////////////////////
    // field widths

    typedef logic [`DR_XLEN-1:0]   xlen_t;
    typedef logic [`DR_PREG_W-1:0] preg_t;
    typedef logic [`DR_ROB_W-1:0]  rob_idx_t;
    typedef logic [`DR_UOPC_W-1:0] uop_code_t;

    //////////////////////////////
    // records

    // what a unit sees in its issue register
    typedef struct packed {
        rob_idx_t  rob_entry;
        preg_t     rs1_reg;
        logic      rs1_received; // operand value already captured
        xlen_t     rs1_value;
        preg_t     rs2_reg;
        logic      rs2_received;
        xlen_t     rs2_value;
        xlen_t     pc;
        uop_code_t uop_encoding;
        preg_t     dest_reg;
    } issue_uop_t;

    // what travels down the ring, the unit id picks the exit stage
    typedef struct packed {
        fu_id_pkg::fu_id_e fu;
        issue_uop_t        uop;
    } dispatch_req_t;

endpackage

// File: hw/ring_entry.sv
module ring_entry (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              in_valid,
    input  dispatch_types_pkg::dispatch_req_t in_req,
    output logic                              in_ready,

    input  logic                              hold,
    output logic                              out_valid,
    output dispatch_types_pkg::dispatch_req_t out_req
);

    logic stalled;

    //////////////////////////////
    // flow control

    // the first slot refuses what sits here, so nothing new gets in
    assign stalled  = out_valid && hold;
    assign in_ready = !stalled;

    //////////////////////////////
    // entry register

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!stalled) begin
            out_valid <= in_valid; // bubbles are loaded too
        end
    end

    always_ff @(posedge clk) begin
        if (!stalled) begin
            out_req <= in_req;
        end
    end

    //////////////////////////////
    // checks

    // an id outside the ring would pass the last stage and be lost
    a_fu_legal: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && in_ready |->
            in_req.fu inside {[fu_id_pkg::FU_LOGICAL:fu_id_pkg::FU_LD_ST]}
    ) else $error("ring_entry: accepted micro-op with illegal unit id %0d", in_req.fu);

    // a request left waiting on the port must not move under the handshake
    a_in_stable: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_req)
    ) else $error("ring_entry: request changed while stalled");

endmodule

// File: hw/ring_slot.sv
module ring_slot #(
    parameter fu_id_pkg::fu_id_e UNIT = fu_id_pkg::FU_ARITH
) (
    input  logic                              clk,
    input  logic                              rst,

    // from the previous stage
    input  logic                              prev_valid,
    input  dispatch_types_pkg::dispatch_req_t prev_req,
    output logic                              hold_out,

    // to the next stage
    output logic                              next_valid,
    output dispatch_types_pkg::dispatch_req_t next_req,
    input  logic                              hold_in = 1'b0,

    // issue port of this stage's unit
    output logic                              issue_valid,
    output dispatch_types_pkg::issue_uop_t    issue_uop,
    input  logic                              issue_ready
);

    localparam bit IS_LAST = (UNIT == fu_id_pkg::FU_LAST);

    logic                              stage_valid;
    dispatch_types_pkg::dispatch_req_t stage_req;
    logic                              mine;
    logic                              issue_free;
    logic                              take;
    logic                              downstream_hold;

    //////////////////////////////
    // tap decode

    assign mine       = stage_valid && (stage_req.fu == UNIT);
    assign issue_free = !issue_valid || issue_ready; // empty, or drained this cycle
    assign take       = mine && issue_free;

    // nothing sits beyond the last stage
    assign downstream_hold = IS_LAST ? 1'b0 : hold_in;

    // a micro-op stuck on either its own unit or the rest of the ring
    assign hold_out = stage_valid && (mine ? !issue_free : downstream_hold);

    // a micro-op for this unit never travels on, it leaves a bubble
    assign next_valid = stage_valid && !mine;
    assign next_req   = stage_req;

    //////////////////////////////
    // stage register

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (!hold_out) begin
            stage_valid <= prev_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_out) begin
            stage_req <= prev_req;
        end
    end

    //////////////////////////////
    // issue register

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (issue_free) begin
            issue_valid <= mine;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            issue_uop <= stage_req.uop;
        end
    end

    //////////////////////////////
    // checks

    // a unit that is not ready sees the same micro-op again next cycle
    a_issue_stable: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_uop)
    ) else $error("ring_slot %s: issue_uop changed while stalled", UNIT.name());

    if (IS_LAST) begin : g_last
        // anything else reaching the end of the open ring would be dropped
        a_last_own: assert property (
            @(posedge clk) disable iff (rst)
            stage_valid |-> stage_req.fu == UNIT
        ) else $error("ring_slot %s: stray micro-op for unit %0d", UNIT.name(), stage_req.fu);
    end

endmodule

// File: hw/dispatch_ring.sv
module dispatch_ring (
    input  logic                              clk,
    input  logic                              rst,

    // issue port
    input  logic                              in_valid,
    input  dispatch_types_pkg::dispatch_req_t in_req,
    output logic                              in_ready,

    // arithmetic unit
    output logic                              arith_valid,
    output dispatch_types_pkg::issue_uop_t    arith_uop,
    input  logic                              arith_ready,

    // logical unit
    output logic                              logical_valid,
    output dispatch_types_pkg::issue_uop_t    logical_uop,
    input  logic                              logical_ready,

    // branch unit
    output logic                              branch_valid,
    output dispatch_types_pkg::issue_uop_t    branch_uop,
    input  logic                              branch_ready,

    // multiply / divide unit
    output logic                              mul_div_valid,
    output dispatch_types_pkg::issue_uop_t    mul_div_uop,
    input  logic                              mul_div_ready,

    // load / store unit
    output logic                              ld_st_valid,
    output dispatch_types_pkg::issue_uop_t    ld_st_uop,
    input  logic                              ld_st_ready
);

    //////////////////////////////
    // ring links

    logic                              entry_valid;
    dispatch_types_pkg::dispatch_req_t entry_req;

    logic                              arith_next_valid;
    dispatch_types_pkg::dispatch_req_t arith_next_req;
    logic                              logical_next_valid;
    dispatch_types_pkg::dispatch_req_t logical_next_req;
    logic                              branch_next_valid;
    dispatch_types_pkg::dispatch_req_t branch_next_req;
    logic                              mul_div_next_valid;
    dispatch_types_pkg::dispatch_req_t mul_div_next_req;

    // each hold runs back to the stage in front
    logic arith_hold;
    logic logical_hold;
    logic branch_hold;
    logic mul_div_hold;
    logic ld_st_hold;

    //////////////////////////////
    // entry

    ring_entry u_entry (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_ready  (in_ready),
        .hold      (arith_hold),
        .out_valid (entry_valid),
        .out_req   (entry_req)
    );

    //////////////////////////////
    // stages

    ring_slot #(.UNIT(fu_id_pkg::RING_ORDER[0])) u_arith (
        .clk         (clk),
        .rst         (rst),
        .prev_valid  (entry_valid),
        .prev_req    (entry_req),
        .hold_out    (arith_hold),
        .next_valid  (arith_next_valid),
        .next_req    (arith_next_req),
        .hold_in     (logical_hold),
        .issue_valid (arith_valid),
        .issue_uop   (arith_uop),
        .issue_ready (arith_ready)
    );

    ring_slot #(.UNIT(fu_id_pkg::RING_ORDER[1])) u_logical (
        .clk         (clk),
        .rst         (rst),
        .prev_valid  (arith_next_valid),
        .prev_req    (arith_next_req),
        .hold_out    (logical_hold),
        .next_valid  (logical_next_valid),
        .next_req    (logical_next_req),
        .hold_in     (branch_hold),
        .issue_valid (logical_valid),
        .issue_uop   (logical_uop),
        .issue_ready (logical_ready)
    );

    ring_slot #(.UNIT(fu_id_pkg::RING_ORDER[2])) u_branch (
        .clk         (clk),
        .rst         (rst),
        .prev_valid  (logical_next_valid),
        .prev_req    (logical_next_req),
        .hold_out    (branch_hold),
        .next_valid  (branch_next_valid),
        .next_req    (branch_next_req),
        .hold_in     (mul_div_hold),
        .issue_valid (branch_valid),
        .issue_uop   (branch_uop),
        .issue_ready (branch_ready)
    );

    ring_slot #(.UNIT(fu_id_pkg::RING_ORDER[3])) u_mul_div (
        .clk         (clk),
        .rst         (rst),
        .prev_valid  (branch_next_valid),
        .prev_req    (branch_next_req),
        .hold_out    (mul_div_hold),
        .next_valid  (mul_div_next_valid),
        .next_req    (mul_div_next_req),
        .hold_in     (ld_st_hold),
        .issue_valid (mul_div_valid),
        .issue_uop   (mul_div_uop),
        .issue_ready (mul_div_ready)
    );

    // the last stage has no downstream so its hold_in keeps the default
    ring_slot #(.UNIT(fu_id_pkg::RING_ORDER[4])) u_ld_st (
        .clk         (clk),
        .rst         (rst),
        .prev_valid  (mul_div_next_valid),
        .prev_req    (mul_div_next_req),
        .hold_out    (ld_st_hold),
        .next_valid  (),
        .next_req    (),
        .issue_valid (ld_st_valid),
        .issue_uop   (ld_st_uop),
        .issue_ready (ld_st_ready)
    );

endmodule

// File: bench/dispatch_ring_checks.sv
module dispatch_ring_checks (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              lat_phase,

    input  logic                              in_valid,
    input  dispatch_types_pkg::dispatch_req_t in_req,
    input  logic                              in_ready,

    input  logic                              arith_valid,
    input  dispatch_types_pkg::issue_uop_t    arith_uop,
    input  logic                              arith_ready,
    input  logic                              logical_valid,
    input  dispatch_types_pkg::issue_uop_t    logical_uop,
    input  logic                              logical_ready,
    input  logic                              branch_valid,
    input  dispatch_types_pkg::issue_uop_t    branch_uop,
    input  logic                              branch_ready,
    input  logic                              mul_div_valid,
    input  dispatch_types_pkg::issue_uop_t    mul_div_uop,
    input  logic                              mul_div_ready,
    input  logic                              ld_st_valid,
    input  dispatch_types_pkg::issue_uop_t    ld_st_uop,
    input  logic                              ld_st_ready,

    output int                                pending,
    output int                                data_errors,
    output int                                protocol_errors
);

    // unit ports indexed by unit id
    logic                           valid_v  [1:5];
    logic                           ready_v  [1:5];
    dispatch_types_pkg::issue_uop_t uop_v    [1:5];
    logic                           stall_q  [1:5];
    dispatch_types_pkg::issue_uop_t held_uop [1:5];
    dispatch_types_pkg::issue_uop_t exp_q    [1:5][$];

    int pending_count  = 0;
    int data_count     = 0;
    int protocol_count = 0;

    assign pending         = pending_count;
    assign data_errors     = data_count;
    assign protocol_errors = protocol_count;

    assign valid_v[1] = logical_valid;
    assign valid_v[2] = arith_valid;
    assign valid_v[3] = branch_valid;
    assign valid_v[4] = mul_div_valid;
    assign valid_v[5] = ld_st_valid;
    assign ready_v[1] = logical_ready;
    assign ready_v[2] = arith_ready;
    assign ready_v[3] = branch_ready;
    assign ready_v[4] = mul_div_ready;
    assign ready_v[5] = ld_st_ready;
    assign uop_v[1]   = logical_uop;
    assign uop_v[2]   = arith_uop;
    assign uop_v[3]   = branch_uop;
    assign uop_v[4]   = mul_div_uop;
    assign uop_v[5]   = ld_st_uop;

    function automatic string unit_name(input int unit);
        case (unit)
            1: return "logical";
            2: return "arith";
            3: return "branch";
            4: return "mul_div";
            default: return "ld_st";
        endcase
    endfunction

    // stages after the entry, arith first
    function automatic int ring_position(input int unit);
        case (unit)
            2: return 1;
            1: return 2;
            3: return 3;
            4: return 4;
            default: return 5;
        endcase
    endfunction

    //////////////////////////////
    // scoreboard

    always @(posedge clk) begin
        dispatch_types_pkg::issue_uop_t expected;
        if (!rst) begin
            for (int u = 1; u <= 5; u++) begin
                if (valid_v[u] && ready_v[u]) begin
                    if (exp_q[u].size() == 0) begin
                        $display("%s issued a micro-op that was never sent", unit_name(u));
                        data_count++;
                    end else begin
                        expected = exp_q[u].pop_front(); // oldest first per unit
                        pending_count--;
                        a_uop_match: assert (uop_v[u] == expected) else begin
                            $display("Fail time=%0t signal=%s_uop expected=%h actual=%h",
                                     $time, unit_name(u), expected, uop_v[u]);
                            data_count++;
                        end
                    end
                end
            end
            if (in_valid && in_ready &&
                in_req.fu inside {[fu_id_pkg::FU_LOGICAL:fu_id_pkg::FU_LD_ST]}) begin
                exp_q[in_req.fu].push_back(in_req.uop);
                pending_count++;
            end
        end
    end

    //////////////////////////////
    // protocol

    always @(posedge clk) begin
        for (int u = 1; u <= 5; u++) begin
            stall_q[u]  <= !rst && valid_v[u] && !ready_v[u];
            held_uop[u] <= uop_v[u];
        end
    end

    a_reset_idle: assert property (
        @(posedge clk) $fell(rst) |-> in_ready && !arith_valid && !logical_valid &&
            !branch_valid && !mul_div_valid && !ld_st_valid
    ) else begin
        $display("outputs were not idle in the first cycle after reset");
        protocol_count++;
    end

    for (genvar u = 1; u <= 5; u++) begin : g_unit
        localparam int POS = ring_position(u);

        a_stable: assert property (
            @(posedge clk) disable iff (rst)
            stall_q[u] |-> valid_v[u] && uop_v[u] == held_uop[u]
        ) else begin
            $display("Fail time=%0t signal=%s_uop expected=%h actual=%h", $time,
                     unit_name(u), $sampled(held_uop[u]), $sampled(uop_v[u]));
            protocol_count++;
        end

        // a lone micro-op with every unit ready has a fixed trip
        a_latency: assert property (
            @(posedge clk) disable iff (rst)
            lat_phase && in_valid && in_ready && in_req.fu == u
                |-> ##(POS + 1) !valid_v[u] ##1 valid_v[u]
        ) else begin
            $display("%s valid did not rise %0d cycles after acceptance", unit_name(u), POS + 1);
            protocol_count++;
        end
    end

endmodule

// File: bench/dispatch_ring_tb.sv
module dispatch_ring_tb;

    localparam int MODE_ALL      = 0;
    localparam int MODE_RANDOM   = 1;
    localparam int MODE_LDST_LOW = 2;
    localparam int SEND_LIMIT    = 200;
    localparam int DRAIN_LIMIT   = 400;

    logic                              clk;
    logic                              rst;
    logic                              lat_phase;
    logic                              in_valid;
    dispatch_types_pkg::dispatch_req_t in_req;
    logic                              in_ready;
    logic                              arith_valid, logical_valid, branch_valid;
    logic                              mul_div_valid, ld_st_valid;
    logic                              arith_ready, logical_ready, branch_ready;
    logic                              mul_div_ready, ld_st_ready;
    dispatch_types_pkg::issue_uop_t    arith_uop, logical_uop, branch_uop;
    dispatch_types_pkg::issue_uop_t    mul_div_uop, ld_st_uop;

    int          pending, data_errors, protocol_errors;
    int          flow_errors;
    int          ready_mode;
    int          cycle_count;
    logic        saw_stall;
    logic        release_on_stall;
    logic [31:0] lcg_state;

    always #2 clk = ~clk;

    dispatch_ring dut (.*);

    dispatch_ring_checks chk (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic dispatch_types_pkg::dispatch_req_t random_req(
        input fu_id_pkg::fu_id_e fu
    );
        dispatch_types_pkg::dispatch_req_t req;
        logic [31:0] r;
        req.fu = fu;
        r = lcg_next();
        req.uop.rob_entry = r[31:24];
        req.uop.rs1_reg   = r[23:16];
        req.uop.rs2_reg   = r[15:8];
        req.uop.dest_reg  = r[7:0];
        if (req.uop.rs1_reg == req.uop.rob_entry) begin
            req.uop.rs1_reg = ~req.uop.rob_entry; // a swap must show up
        end
        r = lcg_next();
        req.uop.rs1_received = r[31];
        req.uop.rs2_received = r[30];
        req.uop.uop_encoding = r[27:24];
        req.uop.rs1_value    = lcg_next();
        req.uop.rs2_value    = lcg_next();
        r = lcg_next();
        req.uop.pc = {r[31:2], 2'b00};
        return req;
    endfunction

    //////////////////////////////
    // drivers

    task automatic drive_readies();
        logic [31:0] r;
        r = lcg_next();
        if (ready_mode == MODE_ALL || (ready_mode == MODE_RANDOM && cycle_count[3])) begin
            {arith_ready, logical_ready, branch_ready, mul_div_ready, ld_st_ready} = '1;
        end else if (ready_mode == MODE_RANDOM) begin
            arith_ready   = |r[31:30];
            logical_ready = |r[29:28];
            branch_ready  = |r[27:26];
            mul_div_ready = |r[25:24];
            ld_st_ready   = |r[23:22];
        end else begin
            {arith_ready, logical_ready, branch_ready, mul_div_ready} = '1;
            ld_st_ready = 1'b0;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        cycle_count++;
        drive_readies();
    endtask

    task automatic send_uop(input fu_id_pkg::fu_id_e fu);
        int tries;
        tries    = 0;
        in_req   = random_req(fu);
        in_valid = 1'b1;
        #1;
        while (!in_ready && tries < SEND_LIMIT) begin
            saw_stall = 1'b1;
            if (release_on_stall && tries == 4) begin
                ready_mode = MODE_ALL; // ld_st starts draining again
            end
            step();
            #1;
            tries++;
        end
        if (!in_ready) begin
            $display("issue port stayed busy for %0d cycles", SEND_LIMIT);
            flow_errors++;
        end
        step();
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int tries;
        tries = 0;
        #1;
        while (pending != 0 && tries < DRAIN_LIMIT) begin
            step();
            #1;
            tries++;
        end
        if (pending != 0) begin
            $display("%0d micro-ops never reached their unit", pending);
            flow_errors++;
        end
        step();
    endtask

    //////////////////////////////
    // sequence

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        rst = 1'b1;
        lat_phase = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        {arith_ready, logical_ready, branch_ready, mul_div_ready, ld_st_ready} = '1;
        flow_errors = 0;
        ready_mode = MODE_ALL;
        cycle_count = 0;
        saw_stall = 1'b0;
        release_on_stall = 1'b0;
        lcg_state = 32'h80260376;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) step();

        lat_phase = 1'b1; // one micro-op per unit, nothing else in flight
        for (int u = 1; u <= 5; u++) begin
            send_uop(fu_id_pkg::fu_id_e'(u));
            wait_drained();
        end
        lat_phase = 1'b0;

        ready_mode = MODE_RANDOM;
        for (int i = 0; i < 60; i++) begin
            r = lcg_next();
            send_uop(fu_id_pkg::fu_id_e'(1 + r[31:16] % 5));
            if (r[3]) begin
                step();
            end
        end
        ready_mode = MODE_ALL;
        wait_drained();

        saw_stall = 1'b0;
        release_on_stall = 1'b1;
        ready_mode = MODE_LDST_LOW;
        for (int i = 0; i < 12; i++) begin
            send_uop(fu_id_pkg::FU_LD_ST);
        end
        release_on_stall = 1'b0;
        ready_mode = MODE_ALL;
        wait_drained();
        a_burst_stalled: assert (saw_stall) else begin
            $display("ld_st burst never pulled in_ready low");
            flow_errors++;
        end

        $display("errors: %0d data, %0d protocol, %0d flow",
                 data_errors, protocol_errors, flow_errors);
        if (data_errors + protocol_errors + flow_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dispatch_ring.f
+incdir+hw
hw/fu_id_pkg.sv
hw/dispatch_types_pkg.sv
hw/ring_entry.sv
hw/ring_slot.sv
hw/dispatch_ring.sv
bench/dispatch_ring_checks.sv
bench/dispatch_ring_tb.sv
